// File: all.f
hw/dmmu_pkg.sv
hw/tlb_wr_if.sv
hw/tlb_ram.sv
hw/dmmu_msr.sv
hw/dmmu_translate.sv
hw/dmmu_top.sv
tb/dmmu_tb.sv

// File: run.sh
#!/bin/sh
# Build the data MMU testbench with Verilator, run it and check for a clean pass

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module dmmu_tb -f all.f -o dmmu_sim; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/dmmu_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
else
   exit 1
fi

// File: tb/dmmu_tb.sv
/*
 * Self-checking testbench for the data-side MMU.
 * Loads TLB entries and status through the MSR port, issues lookups and
 * lets concurrent assertions compare each result with a reference model
 * one cycle after the lookup. Run it through run.sh.
 */

`timescale 1ns/1ps
`default_nettype none

module dmmu_tb;

   localparam int PAGE_SIZE_LOG2 = 13;
   localparam int TLB_SETS_LOG2  = 4;
   localparam int VPN_W          = dmmu_pkg::ADDR_W - PAGE_SIZE_LOG2;
   localparam int SETS           = 2 ** TLB_SETS_LOG2;
   // Tests run for about 2200 cycles
   localparam int MAX_CYCLES     = 4000;

   logic                clk;
   logic                arst_n;
   logic                re;
   logic [VPN_W-1:0]    vpn;
   logic                we;
   logic [VPN_W-1:0]    ppn;
   logic                tlb_miss;
   logic                page_fault;
   logic                uncached;
   logic                msr_we;
   dmmu_pkg::msr_addr_t msr_addr;
   dmmu_pkg::word_t     msr_wdata;
   dmmu_pkg::word_t     msr_rdata;

   // Reference copy of the TLB and the status bits
   dmmu_pkg::word_t mdl_l [SETS];
   dmmu_pkg::word_t mdl_h [SETS];
   logic            mdl_dmme;
   logic            mdl_rm;

   // Expected result of the lookup sampled at the last edge
   logic             chk;
   logic [VPN_W-1:0] exp_ppn;
   logic             exp_miss;
   logic             exp_fault;
   logic             exp_unc;

   integer seed;
   integer cycles = 0;
   string  test_name;

   dmmu_top u_dmmu_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .re         (re),
      .vpn        (vpn),
      .we         (we),
      .ppn        (ppn),
      .tlb_miss   (tlb_miss),
      .page_fault (page_fault),
      .uncached   (uncached),
      .msr_we     (msr_we),
      .msr_addr   (msr_addr),
      .msr_wdata  (msr_wdata),
      .msr_rdata  (msr_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp) else report_mismatch(what, exp, act);
   endtask

   // Lookup result from the translation rules as {ppn, miss, fault, uncached}
   function automatic logic [VPN_W+2:0] expect_lookup(
      input logic [VPN_W-1:0] v, input logic w, input logic en, input logic root,
      input dmmu_pkg::word_t l, input dmmu_pkg::word_t h);
      logic             hit;
      logic             allow;
      logic             miss;
      logic             fault;
      logic             unc;
      logic [VPN_W-1:0] p;
      hit = l[dmmu_pkg::TLBL_V_BIT] && (l[31 -: VPN_W] == v);
      // Root or user permission for a write or a read
      if (root) begin
         allow = w ? h[dmmu_pkg::TLBH_RW_BIT] : h[dmmu_pkg::TLBH_RR_BIT];
      end else begin
         allow = w ? h[dmmu_pkg::TLBH_UW_BIT] : h[dmmu_pkg::TLBH_UR_BIT];
      end
      miss  = en && !hit;
      fault = en && hit && !allow;
      p     = en ? h[31 -: VPN_W] : v;
      // Entry bit or the 0x8 segment when no miss is reported
      unc   = (en && hit && h[dmmu_pkg::TLBH_UNC_BIT]) || (!miss && (p[VPN_W-1 -: 4] == 4'h8));
      return {p, miss, fault, unc};
   endfunction

   // Reference model of the MSR writes and lookups seen at each edge
   always @(posedge clk or negedge arst_n) begin
      logic [VPN_W+2:0] res;
      if (!arst_n) begin
         for (int i = 0; i < SETS; i++) begin
            mdl_l[i] = '0;
            mdl_h[i] = '0;
         end
         mdl_dmme  = 1'b0;
         mdl_rm    = 1'b0;
         chk       <= 1'b0;
         exp_ppn   <= '0;
         exp_miss  <= 1'b0;
         exp_fault <= 1'b0;
         exp_unc   <= 1'b0;
      end else begin
         // TLB writes land first so a same-cycle lookup sees them
         if (msr_we && (msr_addr[1:0] == dmmu_pkg::SEL_TLBL)) begin
            mdl_l[msr_addr[2 +: TLB_SETS_LOG2]] = msr_wdata;
         end
         if (msr_we && (msr_addr[1:0] == dmmu_pkg::SEL_TLBH)) begin
            mdl_h[msr_addr[2 +: TLB_SETS_LOG2]] = msr_wdata;
         end
         if (re) begin
            res = expect_lookup(vpn, we, mdl_dmme, mdl_rm,
                                mdl_l[vpn[TLB_SETS_LOG2-1:0]], mdl_h[vpn[TLB_SETS_LOG2-1:0]]);
            {exp_ppn, exp_miss, exp_fault, exp_unc} <= res;
         end
         chk <= re;
         // Status applies to lookups from the next cycle on
         if (msr_we && (msr_addr[1:0] == dmmu_pkg::SEL_PSR)) begin
            mdl_dmme = msr_wdata[dmmu_pkg::PSR_DMME_BIT];
            mdl_rm   = msr_wdata[dmmu_pkg::PSR_RM_BIT];
         end
      end
   end

   // Result checks one cycle after each lookup
   assert property (@(posedge clk) disable iff (!arst_n) chk |-> (ppn == exp_ppn))
      else report_mismatch("ppn", 32'($sampled(exp_ppn)), 32'($sampled(ppn)));
   assert property (@(posedge clk) disable iff (!arst_n) chk |-> (tlb_miss == exp_miss))
      else report_mismatch("tlb_miss", 32'($sampled(exp_miss)), 32'($sampled(tlb_miss)));
   assert property (@(posedge clk) disable iff (!arst_n) chk |-> (page_fault == exp_fault))
      else report_mismatch("page_fault", 32'($sampled(exp_fault)), 32'($sampled(page_fault)));
   assert property (@(posedge clk) disable iff (!arst_n) chk |-> (uncached == exp_unc))
      else report_mismatch("uncached", 32'($sampled(exp_unc)), 32'($sampled(uncached)));

   // One clock of stimulus on every DUT input
   task automatic drive_cycle(input logic r, input logic [VPN_W-1:0] v, input logic w,
                              input logic mwe, input dmmu_pkg::msr_addr_t a,
                              input dmmu_pkg::word_t d);
      @(posedge clk);
      re        <= r;
      vpn       <= v;
      we        <= w;
      msr_we    <= mwe;
      msr_addr  <= a;
      msr_wdata <= d;
   endtask

   task automatic msr_write(input dmmu_pkg::msr_addr_t a, input dmmu_pkg::word_t d);
      drive_cycle(1'b0, '0, 1'b0, 1'b1, a, d);
   endtask

   task automatic lookup(input logic [VPN_W-1:0] v, input logic w);
      drive_cycle(1'b1, v, w, 1'b0, '0, '0);
   endtask

   // Combinational read checked mid-cycle
   task automatic check_reg(input dmmu_pkg::msr_addr_t a, input dmmu_pkg::word_t exp,
                            input string what);
      drive_cycle(1'b0, '0, 1'b0, 1'b0, a, '0);
      @(negedge clk);
      check_value(what, exp, msr_rdata);
   endtask

   function automatic dmmu_pkg::msr_addr_t tlb_addr(input logic [VPN_W-1:0] v,
                                                    input logic [1:0] sel);
      return dmmu_pkg::msr_addr_t'({v[TLB_SETS_LOG2-1:0], sel});
   endfunction

   function automatic dmmu_pkg::word_t low_word(input logic [VPN_W-1:0] tag, input logic v);
      dmmu_pkg::word_t l;
      l = '0;
      l[31 -: VPN_W] = tag;
      l[dmmu_pkg::TLBL_V_BIT] = v;
      return l;
   endfunction

   function automatic dmmu_pkg::word_t status_word(input logic en, input logic root);
      dmmu_pkg::word_t s;
      s = '0;
      s[dmmu_pkg::PSR_DMME_BIT] = en;
      s[dmmu_pkg::PSR_RM_BIT]   = root;
      return s;
   endfunction

   task automatic write_entry(input logic [VPN_W-1:0] v, input dmmu_pkg::word_t l,
                              input dmmu_pkg::word_t h);
      msr_write(tlb_addr(v, dmmu_pkg::SEL_TLBL), l);
      msr_write(tlb_addr(v, dmmu_pkg::SEL_TLBH), h);
   endtask

   function automatic dmmu_pkg::word_t rand_word();
      dmmu_pkg::word_t r;
      r = $random(seed);
      return r;
   endfunction

   function automatic logic rand_bit();
      dmmu_pkg::word_t r;
      r = $random(seed);
      return r[0];
   endfunction

   // Random page number optionally forced into the 0x8 segment
   function automatic logic [VPN_W-1:0] rand_vpn(input logic seg8);
      dmmu_pkg::word_t r;
      r = $random(seed);
      if (seg8) begin
         r[31:28] = 4'h8;
      end
      return r[31 -: VPN_W];
   endfunction

   initial begin
      logic [VPN_W-1:0] v;
      logic [VPN_W-1:0] va;
      logic [VPN_W-1:0] vb;
      dmmu_pkg::word_t  h;
      seed      = 32'h223c;
      test_name = "reset";
      arst_n    = 1'b0;
      re        = 1'b0;
      vpn       = '0;
      we        = 1'b0;
      msr_we    = 1'b0;
      msr_addr  = '0;
      msr_wdata = '0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // Outputs and registers straight out of reset
      @(negedge clk);
      check_value("ppn", '0, 32'(ppn));
      check_value("tlb_miss", '0, 32'(tlb_miss));
      check_value("page_fault", '0, 32'(page_fault));
      check_value("uncached", '0, 32'(uncached));
      check_reg(dmmu_pkg::SEL_PSR, '0, "status word");
      check_reg(dmmu_pkg::SEL_DMMID, 32'd4, "ID word");

      // Every entry invalid
      for (int i = 0; i < SETS; i++) begin
         write_entry(VPN_W'(i), '0, '0);
      end

      // MMU off gives an identity mapping
      test_name = "mmu disabled";
      for (int i = 0; i < 100; i++) begin
         lookup(rand_vpn(i % 2 == 0), rand_bit());
      end

      // Misses on invalid entries
      test_name = "tlb miss";
      msr_write(dmmu_pkg::SEL_PSR, status_word(1'b1, 1'b0));
      check_reg(dmmu_pkg::SEL_PSR, status_word(1'b1, 1'b0), "status read-back");
      for (int i = 0; i < 16; i++) begin
         v = rand_vpn(i % 4 == 0);
         h = rand_word();
         if (i % 2 == 0) begin
            h[31:28] = 4'h8;
         end
         // Tag matches but the valid bit is clear
         write_entry(v, low_word(v, 1'b0), h);
         lookup(v, rand_bit());
      end
      // Valid entries whose tag differs above the index
      for (int i = 0; i < 32; i++) begin
         v = rand_vpn(1'b0);
         h = rand_word();
         // Segment PPN on a miss is still cached
         if (i % 2 == 0) begin
            h[31:28] = 4'h8;
         end
         write_entry(v, low_word(v ^ VPN_W'(1 << (TLB_SETS_LOG2 + i % 15)), 1'b1), h);
         lookup(v, rand_bit());
      end

      // Hits in all four mode and access combinations
      for (int m = 0; m < 4; m++) begin
         test_name = $sformatf("hit rm=%0d we=%0d", m[1], m[0]);
         msr_write(dmmu_pkg::SEL_PSR, status_word(1'b1, m[1]));
         check_reg(dmmu_pkg::SEL_PSR, status_word(1'b1, m[1]), "status read-back");
         for (int i = 0; i < 150; i++) begin
            v = rand_vpn(i % 5 == 0);
            h = rand_word();
            if (i % 4 == 0) begin
               h[31:28] = 4'h8;
            end
            write_entry(v, low_word(v, 1'b1), h);
            lookup(v, m[0]);
         end
      end

      // TLB word written in the lookup cycle
      test_name = "write bypass";
      msr_write(dmmu_pkg::SEL_PSR, status_word(1'b1, 1'b0));
      for (int i = 0; i < 16; i++) begin
         v = rand_vpn(1'b0);
         h = rand_word();
         // Stale entry at the same index
         write_entry(v, low_word(v ^ VPN_W'(32'h100), 1'b1), rand_word());
         if (i % 2 == 0) begin
            msr_write(tlb_addr(v, dmmu_pkg::SEL_TLBL), low_word(v, 1'b1));
            drive_cycle(1'b1, v, h[1], 1'b1, tlb_addr(v, dmmu_pkg::SEL_TLBH), h);
         end else begin
            msr_write(tlb_addr(v, dmmu_pkg::SEL_TLBH), h);
            drive_cycle(1'b1, v, h[1], 1'b1, tlb_addr(v, dmmu_pkg::SEL_TLBL), low_word(v, 1'b1));
         end
      end

      // Back-to-back lookups on two indices
      test_name = "alternating lookups";
      va = rand_vpn(1'b0);
      vb = rand_vpn(1'b1);
      vb[TLB_SETS_LOG2-1:0] = va[TLB_SETS_LOG2-1:0] ^ TLB_SETS_LOG2'(1);
      write_entry(va, low_word(va, 1'b1), rand_word());
      write_entry(vb, low_word(vb, 1'b1), rand_word());
      for (int i = 0; i < 32; i++) begin
         lookup((i % 2 == 0) ? va : vb, rand_bit());
      end

      // Let the last check run
      drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0);
      repeat (2) @(posedge clk);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/dmmu_top.sv
/*
 * Top level of the data-side MMU.
 * Sets the page size, TLB size and uncached-segment parameters and
 * connects the MSR block and the translator to plain ports.
 */

`timescale 1ns/1ps
`default_nettype none

module dmmu_top #(
   parameter int PAGE_SIZE_LOG2 = 13,
   parameter int TLB_SETS_LOG2  = 4,
   parameter int UNCACHED_SEG   = 1
) (
   input  logic                                       clk,
   input  logic                                       arst_n,
   // Lookup
   input  logic                                       re,
   input  logic [dmmu_pkg::ADDR_W-PAGE_SIZE_LOG2-1:0] vpn,
   input  logic                                       we,
   output logic [dmmu_pkg::ADDR_W-PAGE_SIZE_LOG2-1:0] ppn,
   output logic                                       tlb_miss,
   output logic                                       page_fault,
   output logic                                       uncached,
   // Register access
   input  logic                                       msr_we,
   input  dmmu_pkg::msr_addr_t                        msr_addr,
   input  dmmu_pkg::word_t                            msr_wdata,
   output dmmu_pkg::word_t                            msr_rdata
);

   // Status bits into the translator
   logic dmme;
   logic rm;

   // TLB write channel
   tlb_wr_if #(.IDX_W(TLB_SETS_LOG2)) tlb_wr ();

   dmmu_msr #(
      .TLB_SETS_LOG2 (TLB_SETS_LOG2)
   ) u_msr (
      .clk       (clk),
      .arst_n    (arst_n),
      .msr_we    (msr_we),
      .msr_addr  (msr_addr),
      .msr_wdata (msr_wdata),
      .msr_rdata (msr_rdata),
      .dmme      (dmme),
      .rm        (rm),
      .tlb_wr    (tlb_wr.msr)
   );

   dmmu_translate #(
      .PAGE_SIZE_LOG2 (PAGE_SIZE_LOG2),
      .TLB_SETS_LOG2  (TLB_SETS_LOG2),
      .UNCACHED_SEG   (UNCACHED_SEG)
   ) u_translate (
      .clk        (clk),
      .arst_n     (arst_n),
      .re         (re),
      .vpn        (vpn),
      .we         (we),
      .dmme       (dmme),
      .rm         (rm),
      .tlb_wr     (tlb_wr.xlat),
      .ppn        (ppn),
      .tlb_miss   (tlb_miss),
      .page_fault (page_fault),
      .uncached   (uncached)
   );

endmodule

`default_nettype wire

// File: hw/dmmu_translate.sv
/*
 * Lookup stage of the data MMU.
 * A read-enable strobe captures the request and reads the direct-mapped
 * TLB; the next cycle reports the physical page number, the miss and
 * page-fault flags and the uncached flag. Results hold until the next re.
 */

`timescale 1ns/1ps
`default_nettype none

module dmmu_translate #(
   parameter int PAGE_SIZE_LOG2 = 13,
   parameter int TLB_SETS_LOG2  = 4,
   parameter int UNCACHED_SEG   = 1
) (
   input  logic                                          clk,
   input  logic                                          arst_n,
   // Lookup request
   input  logic                                          re,
   input  logic [dmmu_pkg::ADDR_W-PAGE_SIZE_LOG2-1:0]    vpn,
   input  logic                                          we,
   // Status bits
   input  logic                                          dmme,
   input  logic                                          rm,
   // TLB word writes
   tlb_wr_if.xlat                                        tlb_wr,
   // Lookup result
   output logic [dmmu_pkg::ADDR_W-PAGE_SIZE_LOG2-1:0]    ppn,
   output logic                                          tlb_miss,
   output logic                                          page_fault,
   output logic                                          uncached
);

   // Page number width
   localparam int VPN_W = dmmu_pkg::ADDR_W - PAGE_SIZE_LOG2;
   // Top bit of a TLB word
   localparam int WTOP = dmmu_pkg::WORD_W - 1;

   // Captured request
   logic [VPN_W-1:0] vpn_r;
   logic             we_r;
   logic             dmme_r;
   logic             rm_r;

   // Entry words read out of the TLB
   dmmu_pkg::word_t  tlb_l;
   dmmu_pkg::word_t  tlb_h;

   // Entry fields
   logic             ent_v;
   logic [VPN_W-1:0] ent_tag;
   logic [VPN_W-1:0] ent_ppn;
   logic             ent_uw;
   logic             ent_ur;
   logic             ent_rw;
   logic             ent_rr;
   logic             ent_unc;

   logic             hit;
   logic             perm_denied;
   logic             unc_entry;

   // Request capture, held while re is low
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vpn_r  <= '0;
         we_r   <= 1'b0;
         dmme_r <= 1'b0;
         rm_r   <= 1'b0;
      end else if (re) begin
         vpn_r  <= vpn;
         we_r   <= we;
         dmme_r <= dmme;
         rm_r   <= rm;
      end
   end

   // Low word, valid bit and VPN tag
   tlb_ram #(
      .AW (TLB_SETS_LOG2),
      .DW (dmmu_pkg::WORD_W)
   ) u_tlb_l (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  (vpn[TLB_SETS_LOG2-1:0]),
      .re     (re),
      .dout   (tlb_l),
      .waddr  (tlb_wr.idx),
      .we     (tlb_wr.l_we),
      .din    (tlb_wr.wdata)
   );

   // High word, permissions and PPN
   tlb_ram #(
      .AW (TLB_SETS_LOG2),
      .DW (dmmu_pkg::WORD_W)
   ) u_tlb_h (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr  (vpn[TLB_SETS_LOG2-1:0]),
      .re     (re),
      .dout   (tlb_h),
      .waddr  (tlb_wr.idx),
      .we     (tlb_wr.h_we),
      .din    (tlb_wr.wdata)
   );

   // Field extraction
   assign ent_v   = tlb_l[dmmu_pkg::TLBL_V_BIT];
   assign ent_tag = tlb_l[WTOP -: VPN_W];
   assign ent_ppn = tlb_h[WTOP -: VPN_W];
   assign ent_uw  = tlb_h[dmmu_pkg::TLBH_UW_BIT];
   assign ent_ur  = tlb_h[dmmu_pkg::TLBH_UR_BIT];
   assign ent_rw  = tlb_h[dmmu_pkg::TLBH_RW_BIT];
   assign ent_rr  = tlb_h[dmmu_pkg::TLBH_RR_BIT];
   assign ent_unc = tlb_h[dmmu_pkg::TLBH_UNC_BIT];

   // Full tag compare, the index bits are part of the tag
   assign hit = ent_v && (ent_tag == vpn_r);

   // Pick the permission bit for mode and access type
   always_comb begin
      if (rm_r) begin
         perm_denied = we_r ? !ent_rw : !ent_rr;
      end else begin
         perm_denied = we_r ? !ent_uw : !ent_ur;
      end
   end

   // Flags only count with the MMU on
   assign tlb_miss   = dmme_r && !hit;
   assign page_fault = dmme_r && hit && perm_denied;

   // Identity mapping when disabled
   assign ppn = dmme_r ? ent_ppn : vpn_r;

   // Uncached bit from the entry
   assign unc_entry = dmme_r && hit && ent_unc;

   // Fixed 0x8xxxxxxx segment is uncached as well, MMU on or off
   generate
      if (UNCACHED_SEG != 0) begin : g_unc_seg
         assign uncached = unc_entry || (!tlb_miss && (ppn[VPN_W-1 -: 4] == 4'h8));
      end else begin : g_no_unc_seg
         assign uncached = unc_entry;
      end
   endgenerate

endmodule

`default_nettype wire

// File: hw/dmmu_msr.sv
/*
 * Machine-status register block of the data MMU.
 * Decodes single-cycle register writes, keeps the enable and root-mode
 * bits, forwards TLB word writes to the translator unregistered and
 * returns read data combinationally for the selected register.
 */

`timescale 1ns/1ps
`default_nettype none

module dmmu_msr #(
   parameter int TLB_SETS_LOG2 = 4
) (
   input  logic                clk,
   input  logic                arst_n,
   // Register access
   input  logic                msr_we,
   input  dmmu_pkg::msr_addr_t msr_addr,
   input  dmmu_pkg::word_t     msr_wdata,
   output dmmu_pkg::word_t     msr_rdata,
   // Status bits to the translator
   output logic                dmme,
   output logic                rm,
   // TLB word writes
   tlb_wr_if.msr               tlb_wr
);

   // ID word, reports the TLB size
   localparam dmmu_pkg::word_t DMMID_WORD = dmmu_pkg::word_t'(TLB_SETS_LOG2 % 8);

   logic [1:0]      sel;
   dmmu_pkg::word_t psr_word;

   // Register select from the low address bits
   assign sel = msr_addr[1:0];

   // Status register, cleared means MMU off and user mode
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dmme <= 1'b0;
         rm   <= 1'b0;
      end else if (msr_we && (sel == dmmu_pkg::SEL_PSR)) begin
         dmme <= msr_wdata[dmmu_pkg::PSR_DMME_BIT];
         rm   <= msr_wdata[dmmu_pkg::PSR_RM_BIT];
      end
   end

   // TLB writes pass straight through, same cycle
   assign tlb_wr.l_we  = msr_we && (sel == dmmu_pkg::SEL_TLBL);
   assign tlb_wr.h_we  = msr_we && (sel == dmmu_pkg::SEL_TLBH);
   // Index sits just above the select field
   assign tlb_wr.idx   = msr_addr[2 +: TLB_SETS_LOG2];
   assign tlb_wr.wdata = msr_wdata;

   // Status word read-back
   always_comb begin
      psr_word = '0;
      psr_word[dmmu_pkg::PSR_DMME_BIT] = dmme;
      psr_word[dmmu_pkg::PSR_RM_BIT]   = rm;
   end

   // Read mux, TLB words are write-only
   always_comb begin
      case (sel)
         dmmu_pkg::SEL_PSR:   msr_rdata = psr_word;
         dmmu_pkg::SEL_DMMID: msr_rdata = DMMID_WORD;
         default:             msr_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/tlb_ram.sv
/*
 * Simple dual-port RAM on a single clock.
 * The registered read port loads only while re is high and holds
 * otherwise. A write to the address being read in the same cycle
 * is forwarded to the output register.
 */

`timescale 1ns/1ps
`default_nettype none

module tlb_ram #(
   parameter int AW = 4,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          arst_n,
   // Read port
   input  logic [AW-1:0] raddr,
   input  logic          re,
   output logic [DW-1:0] dout,
   // Write port
   input  logic [AW-1:0] waddr,
   input  logic          we,
   input  logic [DW-1:0] din
);

   // Storage, left uninitialized
   logic [DW-1:0] mem [2**AW];

   // Write hits the read address this cycle
   logic bypass;

   assign bypass = we && (waddr == raddr);

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   // Read port, output held while re is low
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dout <= '0;
      end else if (re) begin
         // New word wins over the stale array entry
         dout <= bypass ? din : mem[raddr];
      end
   end

endmodule

`default_nettype wire

// File: hw/tlb_wr_if.sv
/*
 * TLB word write channel from the MSR block to the translator.
 * One strobe per word half; a strobe is high for a single cycle
 * and carries the entry index and the word to store.
 */

`timescale 1ns/1ps
`default_nettype none

interface tlb_wr_if #(
   parameter int IDX_W = 4
);

   // Low word write strobe
   logic             l_we;
   // High word write strobe
   logic             h_we;
   // Entry index, shared by both halves
   logic [IDX_W-1:0] idx;
   logic [31:0]      wdata;

   // Register block drives the writes
   modport msr (output l_we, output h_we, output idx, output wdata);

   // Translator stores them in its RAMs
   modport xlat (input l_we, input h_we, input idx, input wdata);

endinterface

`default_nettype wire

// File: hw/dmmu_pkg.sv
/*
 * Shared constants for the data-side MMU.
 * Holds the word widths, the MSR register select codes and the
 * bit positions inside the status word and the two TLB entry words.
 * Every design file refers to these by scoped name.
 */

`default_nettype none

package dmmu_pkg;

   // Address and data widths
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // Register and TLB word
   typedef logic [WORD_W-1:0] word_t;

   // MSR address; select in [1:0], TLB index above it
   typedef logic [11:0] msr_addr_t;

   // Register select codes
   localparam logic [1:0] SEL_PSR   = 2'd0;
   localparam logic [1:0] SEL_DMMID = 2'd1;
   localparam logic [1:0] SEL_TLBL  = 2'd2;
   localparam logic [1:0] SEL_TLBH  = 2'd3;

   // Status word bits
   localparam int PSR_DMME_BIT = 0;
   localparam int PSR_RM_BIT   = 1;

   // Low TLB word, VPN tag sits in the top bits
   localparam int TLBL_V_BIT = 0;

   // High TLB word, PPN sits in the top bits
   localparam int TLBH_P_BIT   = 0;
   localparam int TLBH_UW_BIT  = 3;
   localparam int TLBH_UR_BIT  = 4;
   localparam int TLBH_RW_BIT  = 5;
   localparam int TLBH_RR_BIT  = 6;
   localparam int TLBH_UNC_BIT = 7;
   localparam int TLBH_S_BIT   = 8;

endpackage

`default_nettype wire
